// File: decim_halfband.f
rtl/fir_pkg.sv
rtl/dp_ram.sv
rtl/fir_coef_rom.sv
rtl/dsp_mac_slice.sv
rtl/fir_decim_halfband_2x.sv
rtl/decim_halfband_top.sv
tb/tb_clk_gen.sv
tb/decim_halfband_asserts.sv
tb/tb_decim_halfband.sv

// File: rtl/decim_halfband_top.sv
`timescale 1ns/1ns
`default_nettype none

module decim_halfband_top (
    input  logic             reset,
    input  logic             clk,

    input  logic             sample_in_rdy,
    input  fir_pkg::stereo_t sample_in,

    output logic             sample_out_rdy,
    output fir_pkg::stereo_t sample_out
);

    logic [fir_pkg::ccnt_w-1:0]          coef_idx;
    logic signed [fir_pkg::sample_w-1:0] coef;
    fir_pkg::dsp_in_t                    dsp_in_l;
    fir_pkg::dsp_in_t                    dsp_in_r;
    fir_pkg::dsp_out_t                   dsp_out_l;
    fir_pkg::dsp_out_t                   dsp_out_r;

    fir_decim_halfband_2x seq0 (
        .reset          (reset),
        .clk            (clk),
        .sample_in_rdy  (sample_in_rdy),
        .sample_in      (sample_in),
        .coef_idx       (coef_idx),
        .coef           (coef),
        .dsp_in_l       (dsp_in_l),
        .dsp_in_r       (dsp_in_r),
        .dsp_out_l      (dsp_out_l),
        .dsp_out_r      (dsp_out_r),
        .sample_out_rdy (sample_out_rdy),
        .sample_out     (sample_out)
    );

    fir_coef_rom coef_rom0 (
        .coef_idx (coef_idx),
        .coef     (coef)
    );

    // One slice per channel
    dsp_mac_slice dsp_l (
        .reset   (reset),
        .clk     (clk),
        .dsp_in  (dsp_in_l),
        .dsp_out (dsp_out_l)
    );

    dsp_mac_slice dsp_r (
        .reset   (reset),
        .clk     (clk),
        .dsp_in  (dsp_in_r),
        .dsp_out (dsp_out_r)
    );

endmodule

`default_nettype wire

// File: rtl/dp_ram.sv
`timescale 1ns/1ns
`default_nettype none

module dp_ram #(
    parameter int depth  = fir_pkg::ccnt,
    parameter int addr_w = fir_pkg::ccnt_w
) (
    input  logic                  reset,

    // Write port
    input  logic                  wr,
    input  logic [addr_w-1:0]     wr_addr,
    input  fir_pkg::stereo_t      wr_data,

    // Read port, data valid one cycle after rd
    input  logic                  rd,
    input  logic [addr_w-1:0]     rd_addr,
    output fir_pkg::stereo_t      rd_data
);

    fir_pkg::stereo_t mem [depth];

    always_ff @(posedge reset) begin
        if (wr) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read
    always_ff @(posedge reset) begin
        if (rd) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// File: rtl/dsp_mac_slice.sv
`timescale 1ns/1ns
`default_nettype none

module dsp_mac_slice (
    input  logic              reset,
    input  logic              clk,
    input  fir_pkg::dsp_in_t  dsp_in,
    output fir_pkg::dsp_out_t dsp_out
);

    logic [fir_pkg::op_w-1:0]              opmode_q;
    logic signed [fir_pkg::sample_w-1:0]   a_q;
    logic signed [fir_pkg::sample_w-1:0]   b_q;
    logic signed [fir_pkg::acc_w-1:0]      c_q;
    logic signed [2*fir_pkg::sample_w-1:0] prod;
    logic signed [fir_pkg::acc_w-1:0]      x_mux;
    logic signed [fir_pkg::acc_w-1:0]      z_mux;
    logic signed [fir_pkg::acc_w-1:0]      p;

    // Input registers
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            opmode_q <= fir_pkg::dsp_nop;
        end
        else begin
            opmode_q <= dsp_in.opmode;
        end
    end

    always_ff @(posedge reset) begin
        a_q <= dsp_in.a;
        b_q <= dsp_in.b;
        c_q <= dsp_in.c;
    end

    assign prod = a_q * b_q;

    // X and Z adder inputs
    assign x_mux = (opmode_q[1:0] == 2'b01) ? fir_pkg::acc_w'(prod) : '0;

    always_comb begin
        case (opmode_q[3:2])
            2'b10  : z_mux = p;
            2'b11  : z_mux = c_q;
            default: z_mux = '0;
        endcase
    end

    // Accumulator
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            p <= '0;
        end
        else begin
            p <= x_mux + z_mux;
        end
    end

    assign dsp_out.p = p;

endmodule

`default_nettype wire

// File: rtl/fir_coef_rom.sv
`timescale 1ns/1ns
`default_nettype none

module fir_coef_rom (
    input  logic [fir_pkg::ccnt_w-1:0]          coef_idx,
    output logic signed [fir_pkg::sample_w-1:0] coef
);

    // Symmetric halfband taps, entry k equals entry 33-k
    always_comb begin
        case (coef_idx)
            6'd0   : coef = 18'sh00002;
            6'd1   : coef = 18'sh3FFF6;
            6'd2   : coef = 18'sh0001A;
            6'd3   : coef = 18'sh3FFC5;
            6'd4   : coef = 18'sh00071;
            6'd5   : coef = 18'sh3FF36;
            6'd6   : coef = 18'sh0014E;
            6'd7   : coef = 18'sh3FDEF;
            6'd8   : coef = 18'sh00322;
            6'd9   : coef = 18'sh3FB62;
            6'd10  : coef = 18'sh006A5;
            6'd11  : coef = 18'sh3F68B;
            6'd12  : coef = 18'sh00D71;
            6'd13  : coef = 18'sh3EC88;
            6'd14  : coef = 18'sh01DC3;
            6'd15  : coef = 18'sh3CB6A;
            6'd16  : coef = 18'sh0A263;
            // Mirror half
            6'd17  : coef = 18'sh0A263;
            6'd18  : coef = 18'sh3CB6A;
            6'd19  : coef = 18'sh01DC3;
            6'd20  : coef = 18'sh3EC88;
            6'd21  : coef = 18'sh00D71;
            6'd22  : coef = 18'sh3F68B;
            6'd23  : coef = 18'sh006A5;
            6'd24  : coef = 18'sh3FB62;
            6'd25  : coef = 18'sh00322;
            6'd26  : coef = 18'sh3FDEF;
            6'd27  : coef = 18'sh0014E;
            6'd28  : coef = 18'sh3FF36;
            6'd29  : coef = 18'sh00071;
            6'd30  : coef = 18'sh3FFC5;
            6'd31  : coef = 18'sh0001A;
            6'd32  : coef = 18'sh3FFF6;
            6'd33  : coef = 18'sh00002;
            default: coef = 18'sh00000;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/fir_decim_halfband_2x.sv
`timescale 1ns/1ns
`default_nettype none

module fir_decim_halfband_2x (
    input  logic                                reset,
    input  logic                                clk,

    input  logic                                sample_in_rdy,
    input  fir_pkg::stereo_t                    sample_in,

    output logic [fir_pkg::ccnt_w-1:0]          coef_idx,
    input  logic signed [fir_pkg::sample_w-1:0] coef,

    output fir_pkg::dsp_in_t                    dsp_in_l,
    output fir_pkg::dsp_in_t                    dsp_in_r,
    input  fir_pkg::dsp_out_t                   dsp_out_l,
    input  fir_pkg::dsp_out_t                   dsp_out_r,

    output logic                                sample_out_rdy,
    output fir_pkg::stereo_t                    sample_out
);

    // One bit per micro-task
    typedef struct packed {
        logic wait_in;
        logic push_x;
        logic push_y;
        logic clr_line;
        logic mov_i_0;
        logic inc_i;
        logic mov_j_head;
        logic inc_j;
        logic mac_cx;
        logic mac_hy;
        logic mov_res;
        logic rpt;
        logic jp_1;
    } ucode_t;

    fir_pkg::stereo_t                    sample_in_q;
    logic                                in_vld;
    logic [3:0]                          pc;
    ucode_t                              uc;
    logic                                hold;
    logic [fir_pkg::ccnt_w-1:0]          repeat_cnt;
    logic [fir_pkg::ccnt_w-1:0]          repeat_max;
    logic                                repeat_st;
    logic [fir_pkg::ccnt_w-1:0]          i_reg;
    logic [fir_pkg::ccnt_w-1:0]          j_reg;
    logic [fir_pkg::ccnt_w-1:0]          x_head;
    logic [fir_pkg::ycnt_w-1:0]          y_head;
    logic [fir_pkg::ycnt_w-1:0]          y_tail;
    fir_pkg::stereo_t                    line_wr_data;
    fir_pkg::stereo_t                    x_rd_data;
    fir_pkg::stereo_t                    y_rd_data;
    logic signed [fir_pkg::sample_w-1:0] coef_q;
    logic                                mac_x_q;
    logic                                mac_y_q;

    // ------------------------------
    // Input capture
    // ------------------------------
    always_ff @(posedge reset) begin
        if (sample_in_rdy) begin
            sample_in_q <= sample_in;
        end
    end

    // Strobe only counts while waiting
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            in_vld <= 1'b0;
        end
        else begin
            in_vld <= sample_in_rdy & uc.wait_in;
        end
    end

    // ------------------------------
    // Microcode
    // ------------------------------
    always_comb begin
        uc = '0;
        case (pc)
            4'd0: begin
                // Flush both lines with zeros
                uc.rpt      = 1'b1;
                uc.push_x   = 1'b1;
                uc.push_y   = 1'b1;
                uc.clr_line = 1'b1;
            end
            4'd1: uc.wait_in = 1'b1;
            4'd2: uc.push_y  = 1'b1;
            4'd3: uc.wait_in = 1'b1;
            4'd4: begin
                uc.push_x     = 1'b1;
                uc.mov_i_0    = 1'b1;
                uc.mov_j_head = 1'b1;
            end
            4'd5: begin
                uc.rpt    = 1'b1;
                uc.mac_cx = 1'b1;
                uc.inc_i  = 1'b1;
                uc.inc_j  = 1'b1;
            end
            4'd6: uc.mac_hy = 1'b1;
            4'd7: uc = '0;
            4'd8: uc = '0;
            4'd9: begin
                uc.mov_res = 1'b1;
                uc.jp_1    = 1'b1;
            end
            default: uc.jp_1 = 1'b1;
        endcase
    end

    assign repeat_max = uc.rpt ? fir_pkg::ccnt_w'(fir_pkg::ccnt - 1) : '0;
    assign repeat_st  = (repeat_cnt != repeat_max);
    assign hold       = (uc.wait_in & ~in_vld) | (uc.rpt & repeat_st);

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            pc <= 4'd0;
        end
        else if (uc.jp_1) begin
            pc <= 4'd1;
        end
        else if (!hold) begin
            pc <= pc + 4'd1;
        end
    end

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            repeat_cnt <= '0;
        end
        else if (!repeat_st) begin
            repeat_cnt <= '0;
        end
        else begin
            repeat_cnt <= repeat_cnt + 1'b1;
        end
    end

    // ------------------------------
    // Index registers and pointers
    // ------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            i_reg <= '0;
            j_reg <= '0;
        end
        else begin
            if (uc.mov_i_0) begin
                i_reg <= '0;
            end
            else if (uc.inc_i) begin
                i_reg <= i_reg + 1'b1;
            end
            // j walks from the newest sample towards the oldest
            if (uc.mov_j_head) begin
                j_reg <= x_head;
            end
            else if (uc.inc_j) begin
                j_reg <= (j_reg == fir_pkg::ccnt - 1) ? '0 : j_reg + 1'b1;
            end
        end
    end

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            x_head <= '0;
            y_head <= '0;
            y_tail <= fir_pkg::ycnt_w'(fir_pkg::ycnt - 1);
        end
        else begin
            if (uc.push_x) begin
                x_head <= (x_head == '0) ? fir_pkg::ccnt_w'(fir_pkg::ccnt - 1) : x_head - 1'b1;
            end
            if (uc.push_y) begin
                y_head <= (y_head == '0) ? fir_pkg::ycnt_w'(fir_pkg::ycnt - 1) : y_head - 1'b1;
                y_tail <= (y_tail == '0) ? fir_pkg::ycnt_w'(fir_pkg::ycnt - 1) : y_tail - 1'b1;
            end
        end
    end

    assign line_wr_data = uc.clr_line ? '0 : sample_in_q;

    // ------------------------------
    // Delay lines
    // ------------------------------
    dp_ram #(.depth(fir_pkg::ccnt), .addr_w(fir_pkg::ccnt_w)) x_buf_ram (
        .reset   (reset),
        .wr      (uc.push_x),
        .wr_addr (x_head),
        .wr_data (line_wr_data),
        .rd      (uc.mac_cx),
        .rd_addr (j_reg),
        .rd_data (x_rd_data)
    );

    dp_ram #(.depth(fir_pkg::ycnt), .addr_w(fir_pkg::ycnt_w)) y_buf_ram (
        .reset   (reset),
        .wr      (uc.push_y),
        .wr_addr (y_head),
        .wr_data (line_wr_data),
        .rd      (uc.mac_hy),
        .rd_addr (y_tail),
        .rd_data (y_rd_data)
    );

    // ------------------------------
    // DSP operands
    // ------------------------------
    assign coef_idx = i_reg;

    // Coefficient delayed to line up with the RAM read
    always_ff @(posedge reset) begin
        coef_q <= coef;
    end

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            mac_x_q <= 1'b0;
            mac_y_q <= 1'b0;
        end
        else begin
            mac_x_q <= uc.mac_cx;
            mac_y_q <= uc.mac_hy;
        end
    end

    // Idle cycles send nop, which clears the accumulators
    always_comb begin
        dsp_in_l        = '0;
        dsp_in_r        = '0;
        dsp_in_l.opmode = fir_pkg::dsp_nop;
        dsp_in_r.opmode = fir_pkg::dsp_nop;
        if (mac_x_q) begin
            dsp_in_l.opmode = fir_pkg::dsp_mac;
            dsp_in_l.a      = coef_q;
            dsp_in_l.b      = x_rd_data.l;
            dsp_in_r.opmode = fir_pkg::dsp_mac;
            dsp_in_r.a      = coef_q;
            dsp_in_r.b      = x_rd_data.r;
        end
        else if (mac_y_q) begin
            dsp_in_l.opmode = fir_pkg::dsp_mac;
            dsp_in_l.a      = fir_pkg::half_coef;
            dsp_in_l.b      = y_rd_data.l;
            dsp_in_r.opmode = fir_pkg::dsp_mac;
            dsp_in_r.a      = fir_pkg::half_coef;
            dsp_in_r.b      = y_rd_data.r;
        end
    end

    // ------------------------------
    // Result
    // ------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            sample_out_rdy <= 1'b0;
            sample_out     <= '0;
        end
        else if (uc.mov_res) begin
            sample_out_rdy <= 1'b1;
            sample_out.l   <= dsp_out_l.p[fir_pkg::res_lsb +: fir_pkg::sample_w];
            sample_out.r   <= dsp_out_r.p[fir_pkg::res_lsb +: fir_pkg::sample_w];
        end
        else begin
            sample_out_rdy <= 1'b0;
            sample_out     <= '0;
        end
    end

endmodule

`default_nettype wire

// File: rtl/fir_pkg.sv
`default_nettype none

package fir_pkg;

    // ------------------------------
    // Data path widths
    // ------------------------------
    localparam int sample_w = 18;
    localparam int acc_w    = 48;
    localparam int op_w     = 8;

    // Output slice of the accumulator, p[33:16]
    localparam int res_lsb  = 16;

    // ------------------------------
    // Delay line geometry
    // ------------------------------
    // Odd-phase line, one entry per coefficient
    localparam int ccnt     = 34;
    localparam int ccnt_w   = 6;

    // Even-phase line
    localparam int ycnt     = 18;
    localparam int ycnt_w   = 5;

    // Centre tap, 0.5 in Q1.16
    localparam logic signed [sample_w-1:0] half_coef = 18'sh08000;

    // ------------------------------
    // DSP opmodes
    // ------------------------------
    // Bits [1:0] pick X (01 = product), bits [3:2] pick Z (10 = P, 11 = C)
    localparam logic [op_w-1:0] dsp_nop = 8'h00;
    localparam logic [op_w-1:0] dsp_mac = 8'h09;

    // ------------------------------
    // Bundles
    // ------------------------------
    typedef struct packed {
        logic signed [sample_w-1:0] l;
        logic signed [sample_w-1:0] r;
    } stereo_t;

    // Operand bundle into one slice
    typedef struct packed {
        logic        [op_w-1:0]     opmode;
        logic signed [sample_w-1:0] a;
        logic signed [sample_w-1:0] b;
        logic signed [acc_w-1:0]    c;
    } dsp_in_t;

    // Result bundle out of one slice
    typedef struct packed {
        logic signed [acc_w-1:0] p;
    } dsp_out_t;

endpackage

`default_nettype wire

// File: tb/decim_halfband_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module decim_halfband_asserts (
    input logic             reset,
    input logic             clk,
    input logic             sample_in_rdy,
    input logic             sample_out_rdy,
    input fir_pkg::stereo_t sample_out
);

    int fails = 0;

    // Output strobe is a single-cycle pulse
    strobe_one_cycle: assert property (
        @(posedge reset) disable iff (clk)
        sample_out_rdy |=> !sample_out_rdy
    ) else begin
        fails++;
        $error("sample_out_rdy high on two consecutive cycles");
    end

    // Output word is zero between strobes
    out_zero_when_idle: assert property (
        @(posedge reset) disable iff (clk)
        !sample_out_rdy |-> (sample_out == '0)
    ) else begin
        fails++;
        $error("sample_out not zero while sample_out_rdy is low");
    end

    // Every output follows an input strobe 40 cycles before it
    out_after_pair: assert property (
        @(posedge reset) disable iff (clk)
        $rose(sample_out_rdy) |-> $past(sample_in_rdy, 41)
    ) else begin
        fails++;
        $error("sample_out_rdy without an input strobe 40 cycles earlier");
    end

endmodule

bind decim_halfband_top decim_halfband_asserts asrt0 (
    .reset          (reset),
    .clk            (clk),
    .sample_in_rdy  (sample_in_rdy),
    .sample_out_rdy (sample_out_rdy),
    .sample_out     (sample_out)
);

`default_nettype wire

// File: tb/tb_clk_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
    output logic reset,
    output logic clk
);

    // 4 ns clock on the port named reset
    initial begin
        reset = 1'b0;
        forever #2 reset = ~reset;
    end

    // Active-high reset on the port named clk, held for 4 cycles
    initial begin
        clk = 1'b1;
        repeat (4) @(posedge reset);
        @(negedge reset);
        clk = 1'b0;
    end

endmodule

`default_nettype wire

// File: tb/tb_decim_halfband.sv
`timescale 1ns/1ns
`default_nettype none

module tb_decim_halfband;

    // Mode 0 holds the value, 1 flips its sign each sample, 2 draws random values
    typedef struct packed {
        fir_pkg::stereo_t smp;
        logic [7:0]       reps;
        logic [1:0]       mode;
    } stim_t;

    logic             reset;
    logic             clk;
    logic             sample_in_rdy;
    fir_pkg::stereo_t sample_in;
    logic             sample_out_rdy;
    fir_pkg::stereo_t sample_out;

    stim_t            stim [8];
    string            stim_name [8];
    int               rows;
    int               errors;

    // Reference histories with the newest at index 0
    fir_pkg::stereo_t x_hist [34];
    fir_pkg::stereo_t y_hist [17];

    tb_clk_gen clk_gen0 (
        .reset (reset),
        .clk   (clk)
    );

    decim_halfband_top dut0 (
        .reset          (reset),
        .clk            (clk),
        .sample_in_rdy  (sample_in_rdy),
        .sample_in      (sample_in),
        .sample_out_rdy (sample_out_rdy),
        .sample_out     (sample_out)
    );

    // ------------------------------
    // Reference filter
    // ------------------------------
    function automatic logic signed [17:0] coef_val(input int k);
        int m;
        m = (k < 17) ? k : 33 - k;
        case (m)
            0 : return 18'sh00002;
            1 : return 18'sh3FFF6;
            2 : return 18'sh0001A;
            3 : return 18'sh3FFC5;
            4 : return 18'sh00071;
            5 : return 18'sh3FF36;
            6 : return 18'sh0014E;
            7 : return 18'sh3FDEF;
            8 : return 18'sh00322;
            9 : return 18'sh3FB62;
            10: return 18'sh006A5;
            11: return 18'sh3F68B;
            12: return 18'sh00D71;
            13: return 18'sh3EC88;
            14: return 18'sh01DC3;
            15: return 18'sh3CB6A;
            16: return 18'sh0A263;
            default: return 18'sh00000;
        endcase
    endfunction

    // Odd taps plus half of the even sample 16 pairs back, sliced to [33:16]
    function automatic logic signed [17:0] expected_out(input bit right);
        logic signed [17:0] s;
        longint             acc;
        logic [63:0]        acc_bits;
        acc = 0;
        for (int i = 0; i < 34; i++) begin
            s = right ? x_hist[i].r : x_hist[i].l;
            acc += longint'(coef_val(i)) * longint'(s);
        end
        s = right ? y_hist[16].r : y_hist[16].l;
        acc += longint'(32768) * longint'(s);
        acc_bits = acc;
        return acc_bits[33:16];
    endfunction

    task automatic add_row(input string name, input int l, input int r,
                           input int reps, input int mode);
        stim[rows].smp.l = fir_pkg::sample_w'(l);
        stim[rows].smp.r = fir_pkg::sample_w'(r);
        stim[rows].reps  = 8'(reps);
        stim[rows].mode  = 2'(mode);
        stim_name[rows]  = name;
        rows++;
    endtask

    // Strobe one sample, then watch the output for 48 cycles
    task automatic apply_sample(input fir_pkg::stereo_t smp, input bit odd,
                                input string name);
        fir_pkg::stereo_t exp_out;
        bit               want_rdy;
        int               c;
        @(negedge reset);
        sample_in_rdy = 1'b1;
        sample_in     = smp;
        exp_out       = '0;
        if (odd) begin
            for (int k = 33; k > 0; k--) begin
                x_hist[k] = x_hist[k-1];
            end
            x_hist[0] = smp;
            exp_out.l = expected_out(1'b0);
            exp_out.r = expected_out(1'b1);
        end
        else begin
            for (int k = 16; k > 0; k--) begin
                y_hist[k] = y_hist[k-1];
            end
            y_hist[0] = smp;
        end
        for (c = 1; c <= 48; c++) begin
            @(negedge reset);
            sample_in_rdy = 1'b0;
            // Strobe due 40 cycles after the accepting edge
            want_rdy = odd && (c == 41);
            if (sample_out_rdy !== want_rdy) begin
                errors++;
                $display("[ERROR] %s: sample_out_rdy at cycle %0d expected %0b actual %0b",
                         name, c, want_rdy, sample_out_rdy);
            end
            if (want_rdy) begin
                if (sample_out.l !== exp_out.l) begin
                    errors++;
                    $display("[ERROR] %s: left expected %0d actual %0d",
                             name, exp_out.l, sample_out.l);
                end
                if (sample_out.r !== exp_out.r) begin
                    errors++;
                    $display("[ERROR] %s: right expected %0d actual %0d",
                             name, exp_out.r, sample_out.r);
                end
            end
            else if (sample_out !== '0) begin
                errors++;
                $display("[ERROR] %s: idle sample_out expected 0 actual %h", name, sample_out);
            end
        end
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        fir_pkg::stereo_t smp;
        int               idx;
        int               total;
        void'($urandom(59));
        sample_in_rdy = 1'b0;
        sample_in     = '0;
        errors        = 0;
        rows          = 0;
        for (int k = 0; k < 34; k++) begin
            x_hist[k] = '0;
        end
        for (int k = 0; k < 17; k++) begin
            y_hist[k] = '0;
        end

        add_row("first_even_zero",   0,      0,       1,  0);
        add_row("odd_impulse",       65536,  -65536,  1,  0);
        add_row("odd_impulse_tail",  0,      0,       32, 0);
        add_row("even_impulse",      65536,  -131072, 1,  0);
        add_row("even_impulse_tail", 0,      0,       33, 0);
        add_row("full_scale_step",   131071, -131072, 20, 0);
        add_row("alternating_sign",  87381,  -87381,  16, 1);
        add_row("random",            0,      0,       24, 2);

        // Output stays quiet during the line flush
        @(negedge clk);
        repeat (40) begin
            @(negedge reset);
            if (sample_out_rdy !== 1'b0) begin
                errors++;
                $display("[ERROR] line_init: sample_out_rdy expected 0 actual %0b",
                         sample_out_rdy);
            end
            if (sample_out !== '0) begin
                errors++;
                $display("[ERROR] line_init: sample_out expected 0 actual %h", sample_out);
            end
        end

        idx = 0;
        for (int row = 0; row < rows; row++) begin
            for (int n = 0; n < stim[row].reps; n++) begin
                smp = stim[row].smp;
                if (stim[row].mode == 2'd1 && n[0]) begin
                    smp.l = -stim[row].smp.l;
                    smp.r = -stim[row].smp.r;
                end
                else if (stim[row].mode == 2'd2) begin
                    smp.l = fir_pkg::sample_w'($urandom);
                    smp.r = fir_pkg::sample_w'($urandom);
                end
                apply_sample(smp, idx[0], stim_name[row]);
                idx++;
            end
        end

        total = errors + dut0.asrt0.fails;
        $display("Check errors: %0d, assertion errors: %0d, total: %0d",
                 errors, dut0.asrt0.fails, total);
        if (total == 0) begin
            $display("No errors");
        end
        else begin
            $display("Errors found");
        end
        $finish;
    end

    // Watchdog sized from the stimulus table
    initial begin
        int limit;
        #1;
        limit = 200;
        for (int row = 0; row < rows; row++) begin
            limit += 50 * stim[row].reps;
        end
        repeat (limit) @(posedge reset);
        $display("Timeout: run did not finish within %0d cycles", limit);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire
